// File: src/cbm2_load_pkg.sv
// CBM-II loader shared definitions: widths, memory map constants and enums

package cbm2_load_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int ADDR_W  = 25;
	localparam int DATA_W  = 8;

	// Queue entry holds address, data and the clear flag
	localparam int ENTRY_W = ADDR_W + DATA_W + 1;

	localparam int QUEUE_DEPTH = 4;

	// ==============================
	// Download indices
	// ==============================

	typedef enum logic [5:0] {
		ROM_E000 = 6'd2,
		ROM_C000 = 6'd3,
		ROM_8000 = 6'd4,
		ROM_6000 = 6'd5,
		ROM_4000 = 6'd6,
		ROM_2000 = 6'd7,
		ROM_1000 = 6'd8,
		CHAR     = 6'd9
	} load_index_e;

	// ==============================
	// Memory map
	// ==============================

	// Upper nine address bits select a 64 KB segment
	localparam logic [8:0] ROM_SEG  = 9'h00F;
	localparam logic [8:0] CHAR_SEG = 9'h010;

	// I/O block inside the ROM segment
	localparam logic [3:0] ROM_SKIP_NIBBLE = 4'hD;

	localparam logic [ADDR_W-1:0] CHAR_BASE  = 25'h010_0000;
	localparam int                CHAR_LIMIT = 4096;

	// Segment 15 areas that the clear always covers
	localparam logic [ADDR_W-1:0] SEG15_BASE      = 25'h0F_0000;
	localparam logic [ADDR_W-1:0] SEG15_LOW_END   = 25'h0F_0FFF;
	localparam logic [ADDR_W-1:0] SEG15_HIGH_BASE = 25'h0F_D000;
	localparam logic [ADDR_W-1:0] SEG15_HIGH_END  = 25'h0F_DFFF;

	// Model B RAM does not start at segment 0 unless fully populated
	localparam logic [ADDR_W-1:0] B_RAM_BASE = 25'h01_0000;

	// ==============================
	// Clear control
	// ==============================

	typedef enum logic [1:0] {
		RAM_256K = 2'd0,
		RAM_128K = 2'd1,
		RAM_64K  = 2'd2,
		RAM_1M   = 2'd3
	} ram_size_e;

	typedef enum logic [1:0] {
		NONE,
		SEG15,
		ALL
	} clear_mode_e;

	// Sequencer FSM
	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		CLEARING
	} seq_state_e;

endpackage

// File: src/load_sequencer.sv
// Load sequencer: maps download bytes and RAM clear walks into write requests

`timescale 1ns/10ps

module load_sequencer (
	input  logic                                   clk_sys,
	input  logic                                   RESET,
	input  logic                                   dl_active,
	input  logic                                   dl_wr,
	input  logic [5:0]                             dl_index,
	input  logic [cbm2_load_pkg::ADDR_W-1:0]       dl_addr,
	input  logic [cbm2_load_pkg::DATA_W-1:0]       dl_data,
	input  logic                                   clear_req,
	input  cbm2_load_pkg::clear_mode_e             clear_mode,
	input  logic                                   model,
	input  cbm2_load_pkg::ram_size_e               ram_size,
	input  logic [2:0]                             count,
	output logic                                   req_push,
	output logic [cbm2_load_pkg::ADDR_W-1:0]       req_addr,
	output logic [cbm2_load_pkg::DATA_W-1:0]       req_data,
	output logic                                   req_clear,
	output logic                                   dl_wait
);

	cbm2_load_pkg::seq_state_e state;

	// Running address, shared by the download and the clear walk
	logic [cbm2_load_pkg::ADDR_W-1:0] walk_addr;

	logic [cbm2_load_pkg::ADDR_W-1:0] base_addr;
	logic [cbm2_load_pkg::ADDR_W-1:0] byte_addr;
	logic [cbm2_load_pkg::ADDR_W-1:0] clear_start;
	logic [cbm2_load_pkg::DATA_W-1:0] fill_byte;
	logic [3:0]                       pending;
	logic                             index_ok;
	logic                             in_window;
	logic                             byte_ok;
	logic                             start_clear;
	logic                             clear_room;
	logic                             ram_end_hit;

	// ==============================
	// Download address mapping
	// ==============================

	always_comb begin
		index_ok  = 1'b1;
		base_addr = cbm2_load_pkg::CHAR_BASE;
		case (cbm2_load_pkg::load_index_e'(dl_index))
			cbm2_load_pkg::ROM_1000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'h1, 12'h000};
			cbm2_load_pkg::ROM_2000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'h2, 12'h000};
			cbm2_load_pkg::ROM_4000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'h4, 12'h000};
			cbm2_load_pkg::ROM_6000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'h6, 12'h000};
			cbm2_load_pkg::ROM_8000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'h8, 12'h000};
			cbm2_load_pkg::ROM_C000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'hC, 12'h000};
			cbm2_load_pkg::ROM_E000: base_addr = {cbm2_load_pkg::ROM_SEG, 4'hE, 12'h000};
			cbm2_load_pkg::CHAR:     base_addr = cbm2_load_pkg::CHAR_BASE;
			default:                 index_ok  = 1'b0;
		endcase

		// Char bytes stay in their 4 KB, ROM bytes in segment 00F minus the D block
		if (cbm2_load_pkg::load_index_e'(dl_index) == cbm2_load_pkg::CHAR) begin
			in_window = (walk_addr >= cbm2_load_pkg::CHAR_BASE) &&
				(walk_addr < cbm2_load_pkg::CHAR_BASE + cbm2_load_pkg::CHAR_LIMIT);
		end else begin
			in_window = (walk_addr[24:16] == cbm2_load_pkg::ROM_SEG) &&
				(walk_addr[15:12] != cbm2_load_pkg::ROM_SKIP_NIBBLE);
		end

		byte_addr = (dl_addr == '0) ? base_addr : walk_addr;
		byte_ok   = index_ok && ((dl_addr == '0) || in_window);
	end

	// ==============================
	// Clear walk
	// ==============================

	assign start_clear = (state == cbm2_load_pkg::IDLE) && clear_req &&
		(clear_mode != cbm2_load_pkg::NONE);

	always_comb begin
		if (clear_mode == cbm2_load_pkg::SEG15) begin
			clear_start = cbm2_load_pkg::SEG15_BASE;
		end else if (model && (ram_size != cbm2_load_pkg::RAM_1M)) begin
			clear_start = cbm2_load_pkg::B_RAM_BASE;
		end else begin
			clear_start = '0;
		end
	end

	// Top of installed RAM; a full 1M walks straight into segment 15
	always_comb begin
		case (ram_size)
			cbm2_load_pkg::RAM_64K:  ram_end_hit = walk_addr == (model ? 25'h01_FFFF : 25'h00_FFFF);
			cbm2_load_pkg::RAM_128K: ram_end_hit = walk_addr == (model ? 25'h02_FFFF : 25'h01_FFFF);
			cbm2_load_pkg::RAM_256K: ram_end_hit = walk_addr == (model ? 25'h04_FFFF : 25'h03_FFFF);
			default:                 ram_end_hit = 1'b0;
		endcase
	end

	// Segment F gets bit 6 stripes, other RAM a mixed pattern
	assign fill_byte = (walk_addr[19:16] == 4'hF) ?
		{cbm2_load_pkg::DATA_W{walk_addr[6]}} :
		{cbm2_load_pkg::DATA_W{walk_addr[14] ^ walk_addr[3] ^ walk_addr[2]}};

	// Count the push already on its way to the queue as well
	assign pending    = {1'b0, count} + {3'b000, req_push};
	assign clear_room = pending < cbm2_load_pkg::QUEUE_DEPTH;

	assign dl_wait = (count >= 3'd2) || (state == cbm2_load_pkg::CLEARING);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state    <= cbm2_load_pkg::IDLE;
			req_push <= 1'b0;
		end else begin
			req_push <= 1'b0;
			case (state)
				cbm2_load_pkg::IDLE: begin
					if (start_clear) begin
						state     <= cbm2_load_pkg::CLEARING;
						walk_addr <= clear_start;
					end else if (dl_active) begin
						state <= cbm2_load_pkg::LOADING;
					end
				end
				cbm2_load_pkg::LOADING: begin
					if (!dl_active) begin
						state <= cbm2_load_pkg::IDLE;
					end
				end
				default: begin
					if (clear_room) begin
						req_push  <= 1'b1;
						req_addr  <= walk_addr;
						req_data  <= fill_byte;
						req_clear <= 1'b1;
						if (walk_addr == cbm2_load_pkg::SEG15_HIGH_END) begin
							state <= cbm2_load_pkg::IDLE;
						end else if (ram_end_hit) begin
							walk_addr <= cbm2_load_pkg::SEG15_BASE;
						end else if (walk_addr == cbm2_load_pkg::SEG15_LOW_END) begin
							walk_addr <= cbm2_load_pkg::SEG15_HIGH_BASE;
						end else begin
							walk_addr <= walk_addr + 1'b1;
						end
					end
				end
			endcase

			// Dropped bytes leave the running address where it is
			if ((state != cbm2_load_pkg::CLEARING) && !start_clear && dl_wr && byte_ok) begin
				req_push  <= 1'b1;
				req_addr  <= byte_addr;
				req_data  <= dl_data;
				req_clear <= 1'b0;
				walk_addr <= byte_addr + 1'b1;
			end
		end
	end

endmodule

// File: src/req_queue.sv
// Request queue: small circular FIFO holding writes until a memory slot opens

`timescale 1ns/10ps

module req_queue (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              push,
	input  logic [cbm2_load_pkg::ADDR_W-1:0]  push_addr,
	input  logic [cbm2_load_pkg::DATA_W-1:0]  push_data,
	input  logic                              push_clear,
	input  logic                              pop,
	output logic [cbm2_load_pkg::ADDR_W-1:0]  q_addr,
	output logic [cbm2_load_pkg::DATA_W-1:0]  q_data,
	output logic                              q_clear,
	output logic                              entry_valid,
	output logic [2:0]                        count
);

	logic [cbm2_load_pkg::ENTRY_W-1:0] mem [cbm2_load_pkg::QUEUE_DEPTH];
	logic [cbm2_load_pkg::ENTRY_W-1:0] head;

	logic [$clog2(cbm2_load_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(cbm2_load_pkg::QUEUE_DEPTH)-1:0] rd_ptr;

	logic do_push;
	logic do_pop;

	assign do_push = push && (count != cbm2_load_pkg::QUEUE_DEPTH);
	assign do_pop  = pop && entry_valid;

	// Head entry is shown without a register stage
	assign head        = mem[rd_ptr];
	assign q_addr      = head[cbm2_load_pkg::ENTRY_W-1 -: cbm2_load_pkg::ADDR_W];
	assign q_data      = head[cbm2_load_pkg::DATA_W:1];
	assign q_clear     = head[0];
	assign entry_valid = count != 3'd0;

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= {push_addr, push_data, push_clear};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= 3'd0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 3'd1;
				2'b01:   count <= count - 3'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/mem_slot_writer.sv
// Slot writer: drives one memory cycle per I/O slot and tracks loaded ROM areas

`timescale 1ns/10ps

module mem_slot_writer (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              io_cycle,
	input  logic [cbm2_load_pkg::ADDR_W-1:0]  q_addr,
	input  logic [cbm2_load_pkg::DATA_W-1:0]  q_data,
	input  logic                              q_clear,
	input  logic                              entry_valid,
	output logic                              pop,
	output logic                              mem_ce,
	output logic                              mem_we,
	output logic [cbm2_load_pkg::ADDR_W-1:0]  mem_addr,
	output logic [cbm2_load_pkg::DATA_W-1:0]  mem_data,
	output logic [8:0]                        rom_loaded
);

	logic io_cycle_d;
	logic slot_open;
	logic slot_close;
	logic real_byte;

	// Slot opens on the falling edge of io_cycle and closes on the rising edge
	assign slot_open  = !io_cycle && io_cycle_d;
	assign slot_close = io_cycle && !io_cycle_d;

	// Blank or erased images read back as all zeros or all ones
	assign real_byte = (|q_data) && !(&q_data);

	always_ff @(posedge clk_sys) begin
		io_cycle_d <= io_cycle;
		if (slot_open && entry_valid) begin
			mem_addr <= q_addr;
			mem_data <= q_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pop        <= 1'b0;
			mem_ce     <= 1'b0;
			mem_we     <= 1'b0;
			rom_loaded <= '0;
		end else begin
			pop <= slot_open && entry_valid;
			if (slot_open) begin
				// No pending entry still gives an idle read cycle
				mem_ce <= 1'b1;
				mem_we <= entry_valid;
				if (entry_valid && !q_clear && real_byte) begin
					if (q_addr[24:16] == cbm2_load_pkg::ROM_SEG) begin
						rom_loaded[q_addr[15:13]] <= 1'b1;
					end else if (q_addr[24:16] == cbm2_load_pkg::CHAR_SEG) begin
						rom_loaded[8] <= 1'b1;
					end
				end
			end else if (slot_close) begin
				mem_ce <= 1'b0;
				mem_we <= 1'b0;
			end
		end
	end

endmodule

// File: src/cbm2_loader.sv
// CBM-II ROM loader and RAM clearer top: sequencer, request queue and slot writer

`timescale 1ns/10ps

module cbm2_loader (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              dl_active,
	input  logic                              dl_wr,
	input  logic [5:0]                        dl_index,
	input  logic [cbm2_load_pkg::ADDR_W-1:0]  dl_addr,
	input  logic [cbm2_load_pkg::DATA_W-1:0]  dl_data,
	input  logic                              clear_req,
	input  cbm2_load_pkg::clear_mode_e        clear_mode,
	input  logic                              model,
	input  cbm2_load_pkg::ram_size_e          ram_size,
	input  logic                              io_cycle,
	output logic                              mem_ce,
	output logic                              mem_we,
	output logic [cbm2_load_pkg::ADDR_W-1:0]  mem_addr,
	output logic [cbm2_load_pkg::DATA_W-1:0]  mem_data,
	output logic                              dl_wait,
	output logic [8:0]                        rom_loaded
);

	// ==============================
	// Request path
	// ==============================

	logic                             req_push;
	logic [cbm2_load_pkg::ADDR_W-1:0] req_addr;
	logic [cbm2_load_pkg::DATA_W-1:0] req_data;
	logic                             req_clear;
	logic [2:0]                       count;

	// Head of queue towards the writer
	logic                             pop;
	logic [cbm2_load_pkg::ADDR_W-1:0] q_addr;
	logic [cbm2_load_pkg::DATA_W-1:0] q_data;
	logic                             q_clear;
	logic                             entry_valid;

	load_sequencer u_seq (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.clear_req  (clear_req),
		.clear_mode (clear_mode),
		.model      (model),
		.ram_size   (ram_size),
		.count      (count),
		.req_push   (req_push),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_clear  (req_clear),
		.dl_wait    (dl_wait)
	);

	req_queue u_queue (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.push        (req_push),
		.push_addr   (req_addr),
		.push_data   (req_data),
		.push_clear  (req_clear),
		.pop         (pop),
		.q_addr      (q_addr),
		.q_data      (q_data),
		.q_clear     (q_clear),
		.entry_valid (entry_valid),
		.count       (count)
	);

	mem_slot_writer u_writer (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.io_cycle    (io_cycle),
		.q_addr      (q_addr),
		.q_data      (q_data),
		.q_clear     (q_clear),
		.entry_valid (entry_valid),
		.pop         (pop),
		.mem_ce      (mem_ce),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.rom_loaded  (rom_loaded)
	);

endmodule

// File: verif/cbm2_loader_tb.sv
// CBM-II loader testbench: downloads, SEG15 clear, slot timing and ROM flag checks

`timescale 1ns/10ps

module cbm2_loader_tb;

	localparam int TOTAL_WRITES   = 64 + 4100 + 4100 + 8192;
	localparam int TIMEOUT_CYCLES = 3 * TOTAL_WRITES * 4;

	logic                              clk_sys;
	logic                              RESET;
	logic                              dl_active;
	logic                              dl_wr;
	logic [5:0]                        dl_index;
	logic [cbm2_load_pkg::ADDR_W-1:0]  dl_addr;
	logic [cbm2_load_pkg::DATA_W-1:0]  dl_data;
	logic                              clear_req;
	cbm2_load_pkg::clear_mode_e        clear_mode;
	logic                              model;
	cbm2_load_pkg::ram_size_e          ram_size;
	logic                              io_cycle;
	logic                              mem_ce;
	logic                              mem_we;
	logic [cbm2_load_pkg::ADDR_W-1:0]  mem_addr;
	logic [cbm2_load_pkg::DATA_W-1:0]  mem_data;
	logic                              dl_wait;
	logic [8:0]                        rom_loaded;

	// Memory model and expected writes in order
	logic [7:0]  mem_model [logic [24:0]];
	logic [24:0] exp_addr_q [$];
	logic [7:0]  exp_data_q [$];
	logic [24:0] exp_a;
	logic [7:0]  exp_d;
	logic [8:0]  exp_loaded;
	logic        we_prev;
	logic        io_phase;
	int          seed;
	int          errors;
	int          writes_seen;
	int          expected_total;
	int          cycles;

	cbm2_loader u_dut (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.clear_req  (clear_req),
		.clear_mode (clear_mode),
		.model      (model),
		.ram_size   (ram_size),
		.io_cycle   (io_cycle),
		.mem_ce     (mem_ce),
		.mem_we     (mem_we),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.dl_wait    (dl_wait),
		.rom_loaded (rom_loaded)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// I/O slot: two cycles high, two cycles low
	always @(negedge clk_sys) begin
		io_phase <= !io_phase;
		if (io_phase) io_cycle <= !io_cycle;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d of %0d writes seen", cycles, writes_seen,
				expected_total);
			$display("Done: errors found");
			$finish;
		end
	end

	// ==============================
	// Slot timing
	// ==============================

	ce_rise_after_fall: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(io_cycle) |=> $rose(mem_ce))
		else begin errors++; $display("mem_ce did not rise one cycle after io_cycle fell"); end

	ce_rise_source: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(mem_ce) |-> !$past(io_cycle) && $past(io_cycle, 2))
		else begin errors++; $display("mem_ce rose without a falling io_cycle before it"); end

	ce_fall_after_rise: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(io_cycle) |=> !mem_ce)
		else begin errors++; $display("mem_ce still high one cycle after io_cycle rose"); end

	we_inside_ce: assert property (@(posedge clk_sys) disable iff (RESET) mem_we |-> mem_ce)
		else begin errors++; $display("mem_we high while mem_ce is low"); end

	// Each rise of mem_we is one memory write
	always @(posedge clk_sys) begin
		if (!RESET && mem_we && !we_prev) begin
			writes_seen++;
			mem_model[mem_addr] = mem_data;
			if (exp_addr_q.size() == 0) begin
				errors++;
				$display("Unexpected memory write to address %h", mem_addr);
			end else begin
				exp_a = exp_addr_q.pop_front();
				exp_d = exp_data_q.pop_front();
				assert (mem_addr == exp_a) else begin
					errors++;
					$display("MISMATCH mem_addr: got %h expected %h", mem_addr, exp_a);
				end
				assert (mem_data == exp_d) else begin
					errors++;
					$display("MISMATCH mem_data at %h: got %h expected %h", exp_a, mem_data, exp_d);
				end
			end
		end
		we_prev = mem_we;
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [24:0] base_addr_of(input logic [5:0] index);
		case (index)
			cbm2_load_pkg::ROM_1000: return 25'h0F_1000;
			cbm2_load_pkg::ROM_2000: return 25'h0F_2000;
			cbm2_load_pkg::ROM_4000: return 25'h0F_4000;
			cbm2_load_pkg::ROM_6000: return 25'h0F_6000;
			cbm2_load_pkg::ROM_8000: return 25'h0F_8000;
			cbm2_load_pkg::ROM_C000: return 25'h0F_C000;
			cbm2_load_pkg::ROM_E000: return 25'h0F_E000;
			default:                 return cbm2_load_pkg::CHAR_BASE;
		endcase
	endfunction

	function automatic logic in_load_window(input logic [5:0] index, input logic [24:0] addr);
		if (index == cbm2_load_pkg::CHAR) begin
			return (addr >= cbm2_load_pkg::CHAR_BASE) &&
				(addr < cbm2_load_pkg::CHAR_BASE + cbm2_load_pkg::CHAR_LIMIT);
		end
		return (addr[24:16] == cbm2_load_pkg::ROM_SEG) &&
			(addr[15:12] != cbm2_load_pkg::ROM_SKIP_NIBBLE);
	endfunction

	task automatic wait_for_drain();
		while (writes_seen < expected_total) @(negedge clk_sys);
		// A few more slots so that any extra write shows up
		repeat (8) @(negedge clk_sys);
	endtask

	task automatic send_download(input logic [5:0] index, input int nbytes);
		int          n;
		int          rnd;
		logic [24:0] addr;
		logic [7:0]  data;
		logic        dropped;
		addr    = base_addr_of(index);
		dropped = 1'b0;
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_index  = index;
		for (n = 0; n < nbytes; n++) begin
			while (dl_wait) @(negedge clk_sys);
			rnd     = $random(seed);
			data    = rnd[7:0];
			dl_wr   = 1'b1;
			dl_addr = n;
			dl_data = data;
			if (!dropped && in_load_window(index, addr)) begin
				exp_addr_q.push_back(addr);
				exp_data_q.push_back(data);
				expected_total++;
				if (data != 8'h00 && data != 8'hFF) begin
					if (index == cbm2_load_pkg::CHAR) exp_loaded[8] = 1'b1;
					else exp_loaded[addr[15:13]] = 1'b1;
				end
				addr = addr + 1'b1;
			end else begin
				dropped = 1'b1;
			end
			@(negedge clk_sys);
			dl_wr = 1'b0;
			@(negedge clk_sys);
		end
		dl_active = 1'b0;
		wait_for_drain();
		assert (rom_loaded == exp_loaded) else begin
			errors++;
			$display("MISMATCH rom_loaded: got %h expected %h", rom_loaded, exp_loaded);
		end
	endtask

	task automatic run_seg15_clear();
		int          a;
		logic [24:0] addr;
		for (a = 0; a < 8192; a++) begin
			addr = (a < 4096) ? cbm2_load_pkg::SEG15_BASE + a :
				cbm2_load_pkg::SEG15_HIGH_BASE + (a - 4096);
			exp_addr_q.push_back(addr);
			exp_data_q.push_back({8{addr[6]}});
		end
		expected_total += 8192;
		@(negedge clk_sys);
		clear_mode = cbm2_load_pkg::SEG15;
		clear_req  = 1'b1;
		@(negedge clk_sys);
		clear_req = 1'b0;
		// Host stays held off while clear writes are still being pushed
		while (expected_total - writes_seen >= 4) begin
			assert (dl_wait) else begin
				errors++;
				$display("MISMATCH dl_wait: got %h expected 1 with %0d writes left", dl_wait,
					expected_total - writes_seen);
			end
			@(negedge clk_sys);
		end
		wait_for_drain();
		assert (rom_loaded == exp_loaded) else begin
			errors++;
			$display("MISMATCH rom_loaded after clear: got %h expected %h", rom_loaded,
				exp_loaded);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int a;
		seed           = 77009;
		errors         = 0;
		writes_seen    = 0;
		expected_total = 0;
		cycles         = 0;
		exp_loaded     = '0;
		we_prev        = 1'b0;
		io_phase       = 1'b0;
		io_cycle       = 1'b1;
		RESET          = 1'b1;
		dl_active      = 1'b0;
		dl_wr          = 1'b0;
		dl_index       = '0;
		dl_addr        = '0;
		dl_data        = '0;
		clear_req      = 1'b0;
		clear_mode     = cbm2_load_pkg::NONE;
		model          = 1'b0;
		ram_size       = cbm2_load_pkg::RAM_256K;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		assert (!mem_ce && !mem_we && !dl_wait && rom_loaded == '0) else begin
			errors++;
			$display("MISMATCH reset outputs: mem_ce %h mem_we %h dl_wait %h rom_loaded %h",
				mem_ce, mem_we, dl_wait, rom_loaded);
		end
		RESET = 1'b0;

		send_download(cbm2_load_pkg::ROM_E000, 64);
		send_download(cbm2_load_pkg::CHAR, 4100);
		for (a = 0; a < 4; a++) begin
			assert (!mem_model.exists(cbm2_load_pkg::CHAR_BASE + 4096 + a)) else begin
				errors++;
				$display("Character byte written past the 4 KB window");
			end
		end
		send_download(cbm2_load_pkg::ROM_C000, 4100);
		for (a = 0; a < 4096; a++) begin
			assert (!mem_model.exists(25'h0F_D000 + a)) else begin
				errors++;
				$display("ROM byte written into the D block at %h", 25'h0F_D000 + a);
			end
		end
		run_seg15_clear();

		$display("Summary: %0d writes seen, %0d expected, %0d errors", writes_seen,
			expected_total, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: cbm2_loader.f
src/cbm2_load_pkg.sv
src/load_sequencer.sv
src/req_queue.sv
src/mem_slot_writer.sv
src/cbm2_loader.sv
verif/cbm2_loader_tb.sv
